// ==== design/usbd_pkg.sv ====
`default_nettype none

package usbd_pkg;

    //----------------------------------------------------------------------------
    // widths
    //----------------------------------------------------------------------------
    // address bits carried in the request struct
    localparam int AHB_ADDR_W = 12;
    // link endpoint number
    localparam int EP_W = 4;
    // fifo occupancy, wide enough for 4095 entries
    localparam int CNT_W = 12;

    // control endpoint
    localparam logic [EP_W-1:0] EP0 = 4'd0;

    //----------------------------------------------------------------------------
    // register fields
    //----------------------------------------------------------------------------
    // control register
    localparam int CR_EN_BIT       = 0;
    localparam int CR_OUT_IE_BIT   = 31;
    localparam int CR_IN_IE_BIT    = 30;
    localparam int CR_SETUP_IE_BIT = 29;

    // status register low bits, flags share the enable positions
    localparam int SR_ONLINE_BIT  = 0;
    localparam int SR_SUSPEND_BIT = 1;
    localparam int SR_HISPEED_BIT = 2;
    localparam int SR_SETUP_BIT   = 3;
    localparam int SR_EP_LSB      = 4;

    // rx/tx fifo status words
    localparam int FIFO_EMPTY_BIT = 0;
    localparam int FIFO_FULL_BIT  = 16;

    // count word, one half per direction
    localparam int NUM_RX_LSB = 0;
    localparam int NUM_TX_LSB = 16;

    //----------------------------------------------------------------------------
    // types
    //----------------------------------------------------------------------------
    typedef enum logic [2:0] {
        SIZE_BYTE = 3'b000,
        SIZE_HALF = 3'b001,
        SIZE_WORD = 3'b010
    } hsize_e;

    // word index, haddr[6:2]
    typedef enum logic [4:0] {
        CSR_SR       = 5'd0,
        CSR_CR       = 5'd1,
        CSR_RXST     = 5'd2,
        CSR_TXST     = 5'd3,
        CSR_EP0_FIFO = 5'd4,
        CSR_EP0_NUM  = 5'd20
    } csr_idx_e;

    typedef logic [CNT_W-1:0] ep_count_t;

    typedef struct packed {
        logic                  hsel;
        logic [AHB_ADDR_W-1:0] haddr;
        logic [1:0]            htrans;
        hsize_e                hsize;
        logic                  hwrite;
        logic                  hready;
        logic [31:0]           hwdata;
    } ahb_req_t;

    // data phase command
    typedef struct packed {
        logic     rd;
        logic     wr;
        csr_idx_e idx;
        logic [3:0] be;
    } bus_cmd_t;

    // from the link controller
    typedef struct packed {
        logic            link_rst;
        logic            hispeed;
        logic            suspend;
        logic            online;
        logic [EP_W-1:0] ep;
        logic [7:0]      rxdat;
        logic            rxval;
        logic            rxact;
        logic            setup;
        logic            txpop;
        logic            txact;
    } usb_link_in_t;

    // to the link controller
    typedef struct packed {
        logic       rxrdy;
        logic [7:0] txdat;
        logic       txval;
        ep_count_t  txlen;
    } usb_link_out_t;

endpackage

`default_nettype wire

// ==== design/ahb_bus_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_bus_capture #(
    parameter int ADDR_WIDTH = 12
) (
    input  wire logic               hclk,
    input  wire logic               hresetn,
    input  wire usbd_pkg::ahb_req_t ahb_req_i,
    output usbd_pkg::bus_cmd_t      cmd_o
);

    logic                  trans_req;
    logic                  rd_req;
    logic                  wr_req;
    logic                  upd_rd;
    logic                  upd_wr;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic                  rd_q;
    logic                  wr_q;
    logic [3:0]            be_nxt;
    logic [3:0]            be_q;

    // nonseq/seq only, previous transfer done
    assign trans_req = ahb_req_i.hready & ahb_req_i.hsel & ahb_req_i.htrans[1];
    assign rd_req    = trans_req & ~ahb_req_i.hwrite;
    assign wr_req    = trans_req &  ahb_req_i.hwrite;

    // new request, or end of an active one
    assign upd_rd = rd_req | (rd_q & ahb_req_i.hready);
    assign upd_wr = wr_req | (wr_q & ahb_req_i.hready);

    //----------------------------------------------------------------------------
    // byte lanes from size and low address
    //----------------------------------------------------------------------------
    always_comb begin
        case (ahb_req_i.hsize)
            usbd_pkg::SIZE_BYTE: be_nxt = 4'b0001 << ahb_req_i.haddr[1:0];
            // upper or lower pair
            usbd_pkg::SIZE_HALF: be_nxt = ahb_req_i.haddr[1] ? 4'b1100 : 4'b0011;
            default:             be_nxt = 4'b1111;
        endcase
    end

    // address held for the data phase
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            addr_q <= '0;
        end else if (trans_req) begin
            addr_q <= ahb_req_i.haddr[ADDR_WIDTH-1:0];
        end
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
            be_q <= '0;
        end else begin
            if (upd_rd) begin
                rd_q <= rd_req;
            end
            if (upd_wr) begin
                wr_q <= wr_req;
            end
            if (upd_rd | upd_wr) begin
                be_q <= be_nxt;
            end
        end
    end

    assign cmd_o = '{
        rd:  rd_q,
        wr:  wr_q,
        idx: usbd_pkg::csr_idx_e'(addr_q[6:2]),
        be:  be_q
    };

endmodule

`default_nettype wire

// ==== design/ep0_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module ep0_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  wire logic          hclk,
    input  wire logic          hresetn,
    input  wire logic          clear_i,
    input  wire logic          push_i,
    input  wire logic [7:0]    push_data_i,
    input  wire logic          pop_i,
    output logic [7:0]         head_o,
    output usbd_pkg::ep_count_t count_o,
    output logic               empty_o,
    output logic               full_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST = PTR_W'(FIFO_DEPTH - 1);

    logic [7:0]          mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    usbd_pkg::ep_count_t count_q;
    logic                do_push;
    logic                do_pop;

    // wrap at depth, not necessarily a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST) ? '0 : ptr + 1'b1;
    endfunction

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == usbd_pkg::ep_count_t'(FIFO_DEPTH));

    // push on full and pop on empty are dropped
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    // show-ahead head
    assign head_o  = mem[rd_ptr];
    assign count_o = count_q;

    // storage
    always_ff @(posedge hclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else if (clear_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // push and pop together leave count alone
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/usbd_irq_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module usbd_irq_status (
    input  wire logic                   hclk,
    input  wire logic                   hresetn,
    input  wire usbd_pkg::usb_link_in_t link_i,
    input  wire usbd_pkg::bus_cmd_t     cmd_i,
    input  wire logic [31:0]            wdata_i,
    output logic                        out_flag_o,
    output logic                        setup_flag_o,
    output logic [usbd_pkg::EP_W-1:0]   latched_ep_o,
    output logic                        setup_seen_o
);

    logic rxact_q;
    logic setup_q;
    logic rxact_rise;
    logic rxact_fall;
    logic setup_fall;
    logic sr_write;

    //----------------------------------------------------------------------------
    // link edges
    //----------------------------------------------------------------------------
    assign rxact_rise = ~rxact_q & link_i.rxact;
    assign rxact_fall = rxact_q & ~link_i.rxact;
    assign setup_fall = setup_q & ~link_i.setup;

    // w1c access to the status word
    assign sr_write = cmd_i.wr && (cmd_i.idx == usbd_pkg::CSR_SR);

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            rxact_q      <= 1'b0;
            setup_q      <= 1'b0;
            out_flag_o   <= 1'b0;
            setup_flag_o <= 1'b0;
            latched_ep_o <= '0;
        end else if (link_i.link_rst) begin
            // bus reset from the link side
            rxact_q      <= 1'b0;
            setup_q      <= 1'b0;
            out_flag_o   <= 1'b0;
            setup_flag_o <= 1'b0;
            latched_ep_o <= '0;
        end else begin
            rxact_q <= link_i.rxact;
            setup_q <= link_i.setup;

            // endpoint of the packet now arriving
            if (rxact_rise) begin
                latched_ep_o <= link_i.ep;
            end
            // end of an OUT transfer
            if (rxact_fall) begin
                out_flag_o <= 1'b1;
            end
            // end of a SETUP stage
            if (setup_fall) begin
                setup_flag_o <= 1'b1;
            end

            // clear after set, so a clear wins
            if (sr_write) begin
                if (wdata_i[usbd_pkg::CR_OUT_IE_BIT]) begin
                    out_flag_o <= 1'b0;
                end
                if (wdata_i[usbd_pkg::CR_SETUP_IE_BIT]) begin
                    setup_flag_o <= 1'b0;
                end
            end
        end
    end

    // registered setup level, shown in the status word
    assign setup_seen_o = setup_q;

endmodule

`default_nettype wire

// ==== design/usbd_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module usbd_csr (
    input  wire logic                   hclk,
    input  wire logic                   hresetn,
    input  wire usbd_pkg::bus_cmd_t     cmd_i,
    input  wire logic [31:0]            wdata_i,
    input  wire usbd_pkg::usb_link_in_t link_i,
    input  wire logic                   out_flag_i,
    input  wire logic                   setup_flag_i,
    input  wire logic [usbd_pkg::EP_W-1:0] latched_ep_i,
    input  wire logic                   setup_seen_i,
    // receive fifo
    input  wire logic [7:0]             rx_head_i,
    input  wire usbd_pkg::ep_count_t    rx_count_i,
    input  wire logic                   rx_empty_i,
    input  wire logic                   rx_full_i,
    // transmit fifo
    input  wire usbd_pkg::ep_count_t    tx_count_i,
    input  wire logic                   tx_empty_i,
    input  wire logic                   tx_full_i,
    output logic [31:0]                 rdata_o,
    output logic                        rx_pop_o,
    output logic                        tx_push_o,
    output usbd_pkg::ep_count_t         txdat_len_o,
    output logic                        intr_o,
    output logic                        usb_nrst_o
);

    logic [31:0] ctrl_q;
    logic        cr_write;
    logic        fifo_sel;

    assign cr_write = cmd_i.wr && (cmd_i.idx == usbd_pkg::CSR_CR);
    assign fifo_sel = (cmd_i.idx == usbd_pkg::CSR_EP0_FIFO);

    //----------------------------------------------------------------------------
    // control register, per byte lane
    //----------------------------------------------------------------------------
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            ctrl_q <= '0;
        end else if (cr_write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (cmd_i.be[lane]) begin
                    ctrl_q[lane*8 +: 8] <= wdata_i[lane*8 +: 8];
                end
            end
        end
    end

    // tx length follows the count, frozen while sending
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            txdat_len_o <= '0;
        end else if (link_i.link_rst) begin
            txdat_len_o <= '0;
        end else if (!link_i.txact) begin
            txdat_len_o <= tx_count_i;
        end
    end

    // ep0 data port, read pops rx and write pushes tx
    assign rx_pop_o  = cmd_i.rd & fifo_sel;
    assign tx_push_o = cmd_i.wr & fifo_sel;

    //----------------------------------------------------------------------------
    // read mux, zero wait state
    //----------------------------------------------------------------------------
    always_comb begin
        rdata_o = '0;
        if (cmd_i.rd) begin
            case (cmd_i.idx)
                usbd_pkg::CSR_SR: begin
                    rdata_o[usbd_pkg::CR_OUT_IE_BIT]   = out_flag_i;
                    // no IN event from the link, reads zero
                    rdata_o[usbd_pkg::CR_IN_IE_BIT]    = 1'b0;
                    rdata_o[usbd_pkg::CR_SETUP_IE_BIT] = setup_flag_i;
                    rdata_o[usbd_pkg::SR_EP_LSB +: usbd_pkg::EP_W] = latched_ep_i;
                    rdata_o[usbd_pkg::SR_SETUP_BIT]    = setup_seen_i;
                    rdata_o[usbd_pkg::SR_HISPEED_BIT]  = link_i.hispeed;
                    rdata_o[usbd_pkg::SR_SUSPEND_BIT]  = link_i.suspend;
                    rdata_o[usbd_pkg::SR_ONLINE_BIT]   = link_i.online;
                end
                usbd_pkg::CSR_CR: begin
                    rdata_o = ctrl_q;
                end
                usbd_pkg::CSR_RXST: begin
                    rdata_o[usbd_pkg::FIFO_FULL_BIT]  = rx_full_i;
                    rdata_o[usbd_pkg::FIFO_EMPTY_BIT] = rx_empty_i;
                end
                usbd_pkg::CSR_TXST: begin
                    rdata_o[usbd_pkg::FIFO_FULL_BIT]  = tx_full_i;
                    rdata_o[usbd_pkg::FIFO_EMPTY_BIT] = tx_empty_i;
                end
                // stale head if the fifo is empty
                usbd_pkg::CSR_EP0_FIFO: begin
                    rdata_o[7:0] = rx_head_i;
                end
                usbd_pkg::CSR_EP0_NUM: begin
                    rdata_o[usbd_pkg::NUM_TX_LSB +: usbd_pkg::CNT_W] = tx_count_i;
                    rdata_o[usbd_pkg::NUM_RX_LSB +: usbd_pkg::CNT_W] = rx_count_i;
                end
                default: begin
                    rdata_o = '0;
                end
            endcase
        end
    end

    // enabled flags onto one line
    assign intr_o = (ctrl_q[usbd_pkg::CR_OUT_IE_BIT] & out_flag_i) |
                    (ctrl_q[usbd_pkg::CR_SETUP_IE_BIT] & setup_flag_i);

    // link held in reset until enabled
    assign usb_nrst_o = ctrl_q[usbd_pkg::CR_EN_BIT] & hresetn;

endmodule

`default_nettype wire

// ==== design/ahb_usbd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_usbd_top #(
    parameter int ADDR_WIDTH = 12,
    parameter int FIFO_DEPTH = 64
) (
    input  wire logic                   hclk,
    input  wire logic                   hresetn,
    input  wire usbd_pkg::ahb_req_t     ahb_req_i,
    output logic [31:0]                 hrdata_o,
    output logic                        hreadyout_o,
    output logic                        hresp_o,
    input  wire usbd_pkg::usb_link_in_t link_i,
    output usbd_pkg::usb_link_out_t     link_o,
    output logic                        intr_o,
    output logic                        usb_nrst_o
);

    usbd_pkg::bus_cmd_t    cmd;
    logic                  out_flag;
    logic                  setup_flag;
    logic [usbd_pkg::EP_W-1:0] latched_ep;
    logic                  setup_seen;
    logic                  rx_push;
    logic                  rx_pop;
    logic [7:0]            rx_head;
    usbd_pkg::ep_count_t   rx_count;
    logic                  rx_empty;
    logic                  rx_full;
    logic                  tx_push;
    logic                  tx_pop;
    logic [7:0]            tx_head;
    usbd_pkg::ep_count_t   tx_count;
    logic                  tx_empty;
    logic                  tx_full;
    usbd_pkg::ep_count_t   txdat_len;

    // always ready, always OKAY
    assign hreadyout_o = 1'b1;
    assign hresp_o     = 1'b0;

    // only endpoint 0 has a data path
    assign rx_push = link_i.rxval && (link_i.ep == usbd_pkg::EP0);
    assign tx_pop  = link_i.txpop && (link_i.ep == usbd_pkg::EP0);

    assign link_o = '{
        rxrdy: ~rx_full,
        txdat: tx_head,
        txval: ~tx_empty,
        txlen: txdat_len
    };

    //----------------------------------------------------------------------------
    // bus side
    //----------------------------------------------------------------------------
    ahb_bus_capture #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_capture (
        .hclk     (hclk),
        .hresetn  (hresetn),
        .ahb_req_i(ahb_req_i),
        .cmd_o    (cmd)
    );

    usbd_csr u_csr (
        .hclk        (hclk),
        .hresetn     (hresetn),
        .cmd_i       (cmd),
        .wdata_i     (ahb_req_i.hwdata),
        .link_i      (link_i),
        .out_flag_i  (out_flag),
        .setup_flag_i(setup_flag),
        .latched_ep_i(latched_ep),
        .setup_seen_i(setup_seen),
        .rx_head_i   (rx_head),
        .rx_count_i  (rx_count),
        .rx_empty_i  (rx_empty),
        .rx_full_i   (rx_full),
        .tx_count_i  (tx_count),
        .tx_empty_i  (tx_empty),
        .tx_full_i   (tx_full),
        .rdata_o     (hrdata_o),
        .rx_pop_o    (rx_pop),
        .tx_push_o   (tx_push),
        .txdat_len_o (txdat_len),
        .intr_o      (intr_o),
        .usb_nrst_o  (usb_nrst_o)
    );

    usbd_irq_status u_irq (
        .hclk        (hclk),
        .hresetn     (hresetn),
        .link_i      (link_i),
        .cmd_i       (cmd),
        .wdata_i     (ahb_req_i.hwdata),
        .out_flag_o  (out_flag),
        .setup_flag_o(setup_flag),
        .latched_ep_o(latched_ep),
        .setup_seen_o(setup_seen)
    );

    //----------------------------------------------------------------------------
    // ep0 fifos, cleared by link reset
    //----------------------------------------------------------------------------
    ep0_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_rx_fifo (
        .hclk       (hclk),
        .hresetn    (hresetn),
        .clear_i    (link_i.link_rst),
        .push_i     (rx_push),
        .push_data_i(link_i.rxdat),
        .pop_i      (rx_pop),
        .head_o     (rx_head),
        .count_o    (rx_count),
        .empty_o    (rx_empty),
        .full_o     (rx_full)
    );

    ep0_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_tx_fifo (
        .hclk       (hclk),
        .hresetn    (hresetn),
        .clear_i    (link_i.link_rst),
        .push_i     (tx_push),
        .push_data_i(ahb_req_i.hwdata[7:0]),
        .pop_i      (tx_pop),
        .head_o     (tx_head),
        .count_o    (tx_count),
        .empty_o    (tx_empty),
        .full_o     (tx_full)
    );

endmodule

`default_nettype wire

// ==== dv/usbd_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module usbd_props (
    input wire logic                    hclk,
    input wire logic                    hresetn,
    input wire logic                    hreadyout_i,
    input wire logic                    intr_i,
    input wire logic                    out_flag_i,
    input wire logic                    setup_flag_i,
    input wire usbd_pkg::ep_count_t     tx_count_i,
    input wire usbd_pkg::usb_link_out_t link_out_i
);

    // zero wait states
    a_ready_high: assert property (@(posedge hclk) disable iff (!hresetn)
        hreadyout_i)
        else $error("hreadyout dropped low");

    // interrupt needs a raised flag behind it
    a_intr_has_flag: assert property (@(posedge hclk) disable iff (!hresetn)
        intr_i |-> (out_flag_i || setup_flag_i))
        else $error("interrupt high with no flag set");

    // empty tx fifo offers nothing
    a_txval_count: assert property (@(posedge hclk) disable iff (!hresetn)
        (tx_count_i == '0) |-> !link_out_i.txval)
        else $error("tx valid high with an empty tx fifo");

endmodule

bind ahb_usbd_top usbd_props u_props (
    .hclk        (hclk),
    .hresetn     (hresetn),
    .hreadyout_i (hreadyout_o),
    .intr_i      (intr_o),
    .out_flag_i  (out_flag),
    .setup_flag_i(setup_flag),
    .tx_count_i  (tx_count),
    .link_out_i  (link_o)
);

`default_nettype wire

// ==== dv/tb_usbd.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_usbd;

    localparam int ADDR_WIDTH   = 12;
    localparam int FIFO_DEPTH   = 64;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    // trace storage
    localparam int MAX_RECORDS  = 256;
    localparam int MAX_FIELDS   = 6;
    // longest record is a three cycle bus access
    localparam int CYCLES_PER_RECORD = 20;

    logic                    hclk;
    logic                    hresetn;
    usbd_pkg::ahb_req_t      ahb_req;
    usbd_pkg::usb_link_in_t  link_in;
    usbd_pkg::usb_link_out_t link_out;
    logic [31:0]             hrdata;
    logic                    hreadyout;
    logic                    hresp;
    logic                    intr;
    logic                    usb_nrst;

    // one opcode letter and up to six hex fields per record
    logic [7:0]  rec_op  [MAX_RECORDS];
    logic [31:0] rec_arg [MAX_RECORDS][MAX_FIELDS];
    int          num_records;
    logic        trace_loaded = 1'b0;

    ahb_usbd_top #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uut (
        .hclk       (hclk),
        .hresetn    (hresetn),
        .ahb_req_i  (ahb_req),
        .hrdata_o   (hrdata),
        .hreadyout_o(hreadyout),
        .hresp_o    (hresp),
        .link_i     (link_in),
        .link_o     (link_out),
        .intr_o     (intr),
        .usb_nrst_o (usb_nrst)
    );

    initial begin
        hclk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            hclk = ~hclk;
        end
    end

    // -------------------------------------------------------------------------
    // compare and failure helpers
    // -------------------------------------------------------------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "testbench stopped on first failure");
    endtask

    task automatic check_rdata(input usbd_pkg::csr_idx_e idx, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERR %0t: read of index %0d gave %h, expected %h",
                                        $time, idx, got, exp));
        end
    endtask

    task automatic check_link(input usbd_pkg::usb_link_out_t got,
                              input usbd_pkg::usb_link_out_t exp);
        usbd_pkg::usb_link_out_t want;
        want = exp;
        // head byte means nothing while tx is empty
        if (!exp.txval) begin
            want.txdat = got.txdat;
        end
        if (got !== want) begin
            stop_with_failure($sformatf(
                "ERR %0t: link rxrdy %b txdat %h txval %b txlen %h, expected %b %h %b %h",
                $time, got.rxrdy, got.txdat, got.txval, got.txlen,
                want.rxrdy, want.txdat, want.txval, want.txlen));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERR %0t: %s is %b, expected %b",
                                        $time, name, got, exp));
        end
    endtask

    // number of hex fields after each opcode
    function automatic int field_count(input logic [7:0] op);
        case (op)
            "W":                     return 4;
            "R":                     return 2;
            "C":                     return 6;
            "E", "A", "S", "T", "B": return 1;
            "P", "L":                return 0;
            default:                 return -1;
        endcase
    endfunction

    task automatic load_trace();
        int               fd;
        int               code;
        int               nfields;
        logic [7:0]       op;
        logic [31:0]      val;
        logic [8*160-1:0] skip_line;
        fd = $fopen("dv/usbd_trace.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open the trace file dv/usbd_trace.txt");
        end
        num_records = 0;
        code = $fscanf(fd, "%s", op);
        while (code == 1) begin
            if (op == "#") begin
                // rest of a comment line
                code = $fgets(skip_line, fd);
            end else begin
                nfields = field_count(op);
                if (nfields < 0 || num_records >= MAX_RECORDS) begin
                    stop_with_failure("trace has an unknown record or too many records");
                end
                rec_op[num_records] = op;
                for (int k = 0; k < nfields; k++) begin
                    code = $fscanf(fd, "%h", val);
                    if (code != 1) begin
                        stop_with_failure("trace record is missing a field");
                    end
                    rec_arg[num_records][k] = val;
                end
                num_records++;
            end
            code = $fscanf(fd, "%s", op);
        end
        $fclose(fd);
    endtask

    // -------------------------------------------------------------------------
    // bus and link drivers on the falling edge
    // -------------------------------------------------------------------------
    task automatic bus_write(input usbd_pkg::csr_idx_e idx, input usbd_pkg::hsize_e size,
                             input logic [1:0] lane, input logic [31:0] data);
        @(negedge hclk);
        ahb_req.hsel       = 1'b1;
        ahb_req.haddr      = '0;
        ahb_req.haddr[6:2] = idx;
        ahb_req.haddr[1:0] = lane;
        ahb_req.htrans     = 2'b10;
        ahb_req.hsize      = size;
        ahb_req.hwrite     = 1'b1;
        // data phase with the bus idle
        @(negedge hclk);
        ahb_req.hsel   = 1'b0;
        ahb_req.htrans = 2'b00;
        ahb_req.hwrite = 1'b0;
        ahb_req.hwdata = data;
    endtask

    task automatic bus_read(input usbd_pkg::csr_idx_e idx, input logic [31:0] exp);
        @(negedge hclk);
        ahb_req.hsel       = 1'b1;
        ahb_req.haddr      = '0;
        ahb_req.haddr[6:2] = idx;
        ahb_req.htrans     = 2'b10;
        ahb_req.hsize      = usbd_pkg::SIZE_WORD;
        ahb_req.hwrite     = 1'b0;
        // zero wait state so data is valid mid data phase
        @(negedge hclk);
        check_rdata(idx, hrdata, exp);
        // slave is always ready with an OKAY response
        check_flag("hreadyout_o", hreadyout, 1'b1);
        check_flag("hresp_o", hresp, 1'b0);
        ahb_req.hsel   = 1'b0;
        ahb_req.htrans = 2'b00;
    endtask

    task automatic rx_byte(input logic [7:0] data);
        @(negedge hclk);
        link_in.rxval = 1'b1;
        link_in.rxdat = data;
        @(negedge hclk);
        link_in.rxval = 1'b0;
    endtask

    task automatic tx_pop_once();
        @(negedge hclk);
        link_in.txpop = 1'b1;
        @(negedge hclk);
        link_in.txpop = 1'b0;
    endtask

    task automatic link_reset_once();
        @(negedge hclk);
        link_in.link_rst = 1'b1;
        @(negedge hclk);
        link_in.link_rst = 1'b0;
    endtask

    task automatic run_record(input int i);
        usbd_pkg::usb_link_out_t exp_link;
        case (rec_op[i])
            "W": bus_write(usbd_pkg::csr_idx_e'(rec_arg[i][0][4:0]),
                           usbd_pkg::hsize_e'(rec_arg[i][1][2:0]),
                           rec_arg[i][2][1:0], rec_arg[i][3]);
            "R": bus_read(usbd_pkg::csr_idx_e'(rec_arg[i][0][4:0]), rec_arg[i][1]);
            "B": rx_byte(rec_arg[i][0][7:0]);
            "P": tx_pop_once();
            "L": link_reset_once();
            // level changes on the link side
            "E": begin
                @(negedge hclk);
                link_in.ep = rec_arg[i][0][3:0];
            end
            "A": begin
                @(negedge hclk);
                link_in.rxact = rec_arg[i][0][0];
            end
            "S": begin
                @(negedge hclk);
                link_in.setup = rec_arg[i][0][0];
            end
            "T": begin
                @(negedge hclk);
                link_in.txact = rec_arg[i][0][0];
            end
            "C": begin
                @(negedge hclk);
                exp_link.rxrdy = rec_arg[i][0][0];
                exp_link.txdat = rec_arg[i][1][7:0];
                exp_link.txval = rec_arg[i][2][0];
                exp_link.txlen = rec_arg[i][3][11:0];
                check_link(link_out, exp_link);
                check_flag("intr_o", intr, rec_arg[i][4][0]);
                check_flag("usb_nrst_o", usb_nrst, rec_arg[i][5][0]);
            end
            default: stop_with_failure($sformatf("record %0d has no handler", i));
        endcase
    endtask

    initial begin : main
        ahb_req        = '0;
        ahb_req.hready = 1'b1;
        link_in        = '0;
        hresetn        = 1'b0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge hclk);
        @(negedge hclk);
        hresetn = 1'b1;
        for (int i = 0; i < num_records; i++) begin
            run_record(i);
        end
        @(negedge hclk);
        $display("RESULT: PASS");
        $finish;
    end

    // run length scales with the trace
    initial begin : watchdog
        int budget;
        wait (trace_loaded);
        budget = num_records * CYCLES_PER_RECORD + RESET_CYCLES + 2;
        repeat (budget) @(posedge hclk);
        stop_with_failure("timeout, the trace did not finish within its cycle budget");
    end

endmodule

`default_nettype wire

// ==== dv/usbd_trace.txt ====
# ops, fields in hex: W idx size lane data | R idx expect | E ep | A rxact | S setup | T txact
# B rxbyte | P tx pop | L link reset | C rxrdy txdat txval txlen intr nrst
# control register, per lane writes
W 01 2 0 20000001
R 01 20000001
W 01 0 2 ffabffff
R 01 20ab0001
W 01 1 2 8000ffff
R 01 80000001
W 01 1 0 ffff5501
R 01 80005501
W 01 2 0 00000001
C 1 00 0 000 0 1
# receive path on ep0
A 1
B 11
B 22
B 33
A 0
R 14 00000003
R 02 00000000
R 00 80000000
C 1 00 0 000 0 1
R 04 00000011
R 04 00000022
R 04 00000033
R 02 00000001
R 14 00000000
# interrupt flags and latched endpoint
W 01 0 3 80000000
C 1 00 0 000 1 1
W 00 2 0 80000000
C 1 00 0 000 0 1
R 00 00000000
E 3
A 1
A 0
E 0
S 1
S 0
R 00 a0000030
C 1 00 0 000 1 1
W 00 2 0 80000000
R 00 20000030
C 1 00 0 000 0 1
W 01 0 3 20000000
C 1 00 0 000 1 1
W 00 2 0 ffffffff
R 00 00000030
C 1 00 0 000 0 1
# transmit path
W 04 0 0 000000a5
W 04 2 0 0000005a
R 14 00020000
R 03 00000000
C 1 a5 1 002 0 1
T 1
P
C 1 5a 1 002 0 1
P
C 1 00 0 002 0 1
T 0
C 1 00 0 000 0 1
# link reset
B 44
B 55
W 04 0 0 00000077
A 1
A 0
R 14 00010002
R 00 80000000
L
R 14 00000000
R 00 00000000
R 02 00000001
R 03 00000001
C 1 00 0 000 0 1
# link enable
W 01 2 0 00000000
C 1 00 0 000 0 0
W 01 0 0 00000001
C 1 00 0 000 0 1

// ==== tb.f ====
design/usbd_pkg.sv
design/ahb_bus_capture.sv
design/ep0_fifo.sv
design/usbd_irq_status.sv
design/usbd_csr.sv
design/ahb_usbd_top.sv
dv/usbd_props.sv
dv/tb_usbd.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the usbd testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_usbd \
    -o tb_usbd_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_usbd_sim > sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation ended early"; exit 1; }
exit 0
